// File: source/miner_defs.svh
/*
 * Screen geometry, object sizes, palette and counts for the miner display.
 * Include wherever one of these constants is needed.
 */
`ifndef MINER_DEFS_SVH
`define MINER_DEFS_SVH

// screen in pixels, both fit in 6 bits
`define MINER_SCR_W         40
`define MINER_SCR_H         30

`define MINER_ITEM_W        3
`define MINER_ITEM_H        2
`define MINER_HOOK_W        2
`define MINER_HOOK_H        3

// banners sit in the middle of the screen
`define MINER_BANNER_W      20
`define MINER_BANNER_H      6
`define MINER_BANNER_X      10
`define MINER_BANNER_Y      12

`define MINER_FRAME_DIV     2048

// items per kind at level 0, one more of each per level
`define MINER_BASE_GOLD     2
`define MINER_BASE_STONE    2
`define MINER_BASE_DIAMOND  1

// 3-bit palette has eight entries, so the number bar reuses the hook color
`define MINER_COL_BG        3'b000
`define MINER_COL_STONE     3'b001
`define MINER_COL_START     3'b010
`define MINER_COL_DIAMOND   3'b011
`define MINER_COL_OVER      3'b100
`define MINER_COL_NEXT      3'b101
`define MINER_COL_GOLD      3'b110
`define MINER_COL_HOOK      3'b111
`define MINER_COL_NUM       3'b111

`define MINER_LFSR_SEED     16'hace1

`endif

// File: source/miner_pkg.sv
/*
 * Enumerations shared by the view blocks: the drawable objects and the
 * sequencer states. Import into a module header where needed.
 */
`default_nettype none

package miner_pkg;

	// objects the painter knows how to draw
	typedef enum logic [3:0] {
		OBJ_BG,
		OBJ_GOLD,
		OBJ_STONE,
		OBJ_DIAMOND,
		OBJ_HOOK0,
		OBJ_HOOK1,
		OBJ_NUM,
		OBJ_START,
		OBJ_OVER,
		OBJ_NEXT
	} draw_obj_t;

	// view sequencer states
	typedef enum logic [4:0] {
		ST_BOOT,
		ST_CMD,
		ST_WAIT,
		ST_NEXT,
		ST_GO_WAIT,
		ST_CLEAR,
		ST_GAME,
		ST_OVER_PRESS,
		ST_OVER_RELEASE,
		ST_NEXT_PRESS,
		ST_LEVEL_UP
	} view_state_t;

endpackage

`default_nettype wire

// File: source/frame_tick.sv
/*
 * Free-running divider that gives a one-cycle frame strobe
 * every MINER_FRAME_DIV clocks, counted from reset.
 */
`timescale 1ns/1ps
`default_nettype none

`include "miner_defs.svh"

module frame_tick (
	input  wire  clk,
	input  wire  resetn,
	output logic frame
);

	localparam int CW = $clog2(`MINER_FRAME_DIV);

	logic [CW-1:0] cnt;

	// strobe on the last count of the period
	assign frame = (cnt == CW'(`MINER_FRAME_DIV - 1));

	always_ff @(posedge clk) begin
		if (!resetn) begin
			cnt <= '0;
		end else if (frame) begin
			cnt <= '0;
		end else begin
			cnt <= cnt + 1'b1;
		end
	end

endmodule

`default_nettype wire

// File: source/item_placer.sv
/*
 * Item positions from a Galois LFSR plus the per-kind item counts and
 * the level register. Restart with place_reset, advance with place_step.
 */
`timescale 1ns/1ps
`default_nettype none

`include "miner_defs.svh"

module item_placer import miner_pkg::*; (
	input  wire        clk,
	input  wire        resetn,
	input  wire        place_reset,
	input  wire        place_step,
	input  wire        level_up,
	input  draw_obj_t  draw_obj,
	output logic [5:0] item_x,
	output logic [5:0] item_y,
	output logic       gold_full,
	output logic       stone_full,
	output logic       diamond_full,
	output logic [3:0] level
);

	// x^16 + x^14 + x^13 + x^11 + 1
	localparam logic [15:0] TAPS = 16'hb400;
	localparam int X_SPAN = `MINER_SCR_W - `MINER_ITEM_W + 1;
	localparam int Y_MIN  = 8;
	localparam int Y_SPAN = `MINER_SCR_H - `MINER_ITEM_H - Y_MIN + 1;

	logic [15:0] lfsr;
	logic [4:0]  gold_cnt, stone_cnt, diamond_cnt;
	logic [7:0]  x_mod, y_mod;

	always_ff @(posedge clk) begin
		if (!resetn || place_reset) begin
			lfsr        <= `MINER_LFSR_SEED;
			gold_cnt    <= '0;
			stone_cnt   <= '0;
			diamond_cnt <= '0;
		end else if (place_step) begin
			lfsr <= (lfsr >> 1) ^ (lfsr[0] ? TAPS : 16'h0000);
			case (draw_obj)
				OBJ_GOLD:    gold_cnt    <= gold_cnt + 5'd1;
				OBJ_STONE:   stone_cnt   <= stone_cnt + 5'd1;
				OBJ_DIAMOND: diamond_cnt <= diamond_cnt + 5'd1;
				default:     ;
			endcase
		end
	end

	// level survives place_reset and stops at 15
	always_ff @(posedge clk) begin
		if (!resetn) begin
			level <= '0;
		end else if (level_up && level != 4'hf) begin
			level <= level + 4'd1;
		end
	end

	assign gold_full    = gold_cnt    >= 5'(`MINER_BASE_GOLD)    + {1'b0, level};
	assign stone_full   = stone_cnt   >= 5'(`MINER_BASE_STONE)   + {1'b0, level};
	assign diamond_full = diamond_cnt >= 5'(`MINER_BASE_DIAMOND) + {1'b0, level};

	// low byte picks the column, high byte the row below the hooks
	assign x_mod  = lfsr[7:0] % 8'(X_SPAN);
	assign y_mod  = lfsr[15:8] % 8'(Y_SPAN);
	assign item_x = x_mod[5:0];
	assign item_y = 6'(Y_MIN) + y_mod[5:0];

endmodule

`default_nettype wire

// File: source/rect_painter.sv
/*
 * Solid rectangle painter. A draw_start latches the geometry of draw_obj,
 * then one pixel write per clock follows, x first, and draw_done closes it.
 */
`timescale 1ns/1ps
`default_nettype none

`include "miner_defs.svh"

module rect_painter import miner_pkg::*; (
	input  wire        clk,
	input  wire        resetn,
	input  wire        draw_start,
	input  draw_obj_t  draw_obj,
	input  wire  [5:0] item_x,
	input  wire  [5:0] item_y,
	input  wire  [3:0] level,
	output logic [5:0] pix_x,
	output logic [5:0] pix_y,
	output logic [2:0] pix_color,
	output logic       pix_we,
	output logic       draw_done
);

	logic [5:0] sel_x, sel_y, sel_w, sel_h;
	logic [2:0] sel_color;
	logic [5:0] org_x, org_y, rect_w, rect_h;
	logic [2:0] color;
	logic [5:0] x_cnt, y_cnt;
	logic       busy;

	// geometry lookup
	always_comb begin
		sel_x     = 6'(`MINER_BANNER_X);
		sel_y     = 6'(`MINER_BANNER_Y);
		sel_w     = 6'(`MINER_BANNER_W);
		sel_h     = 6'(`MINER_BANNER_H);
		sel_color = `MINER_COL_START;
		case (draw_obj)
			OBJ_BG: begin
				sel_x     = '0;
				sel_y     = '0;
				sel_w     = 6'(`MINER_SCR_W);
				sel_h     = 6'(`MINER_SCR_H);
				sel_color = `MINER_COL_BG;
			end
			OBJ_GOLD, OBJ_STONE, OBJ_DIAMOND: begin
				sel_x     = item_x;
				sel_y     = item_y;
				sel_w     = 6'(`MINER_ITEM_W);
				sel_h     = 6'(`MINER_ITEM_H);
				sel_color = (draw_obj == OBJ_GOLD)  ? `MINER_COL_GOLD :
				            (draw_obj == OBJ_STONE) ? `MINER_COL_STONE : `MINER_COL_DIAMOND;
			end
			OBJ_HOOK0, OBJ_HOOK1: begin
				sel_x     = (draw_obj == OBJ_HOOK0) ? 6'd19 : 6'd10;
				sel_y     = 6'd1;
				sel_w     = 6'(`MINER_HOOK_W);
				sel_h     = 6'(`MINER_HOOK_H);
				sel_color = `MINER_COL_HOOK;
			end
			OBJ_NUM: begin
				sel_x     = '0;
				sel_y     = '0;
				sel_w     = {2'b00, level} + 6'd1;
				sel_h     = 6'd1;
				sel_color = `MINER_COL_NUM;
			end
			OBJ_OVER: sel_color = `MINER_COL_OVER;
			OBJ_NEXT: sel_color = `MINER_COL_NEXT;
			default:  ;
		endcase
	end

	always_ff @(posedge clk) begin
		if (draw_start) begin
			org_x  <= sel_x;
			org_y  <= sel_y;
			rect_w <= sel_w;
			rect_h <= sel_h;
			color  <= sel_color;
		end
	end

	// raster walk
	always_ff @(posedge clk) begin
		if (!resetn) begin
			busy      <= 1'b0;
			draw_done <= 1'b0;
			x_cnt     <= '0;
			y_cnt     <= '0;
		end else begin
			draw_done <= 1'b0;
			if (draw_start) begin
				busy  <= 1'b1;
				x_cnt <= '0;
				y_cnt <= '0;
			end else if (busy) begin
				if (x_cnt == rect_w - 6'd1) begin
					x_cnt <= '0;
					if (y_cnt == rect_h - 6'd1) begin
						busy      <= 1'b0;
						draw_done <= 1'b1;
					end else begin
						y_cnt <= y_cnt + 6'd1;
					end
				end else begin
					x_cnt <= x_cnt + 6'd1;
				end
			end
		end
	end

	assign pix_x     = org_x + x_cnt;
	assign pix_y     = org_y + y_cnt;
	assign pix_color = color;
	assign pix_we    = busy;

endmodule

`default_nettype wire

// File: source/view_sequencer.sv
/*
 * Screen ordering FSM. Issues one draw command at a time to the painter:
 * title, background, items, hooks, number bar, then end-of-game banners.
 */
`timescale 1ns/1ps
`default_nettype none

module view_sequencer import miner_pkg::*; (
	input  wire       clk,
	input  wire       resetn,
	input  wire       go,
	input  wire       mode,
	input  wire       game_end,
	input  wire       next_level,
	input  wire       frame,
	input  wire       draw_done,
	input  wire       gold_full,
	input  wire       stone_full,
	input  wire       diamond_full,
	output logic      draw_start,
	output draw_obj_t draw_obj,
	output logic      place_reset,
	output logic      place_step,
	output logic      level_up
);

	view_state_t state, state_d;
	draw_obj_t   obj, obj_d;
	logic        item_kind;

	assign item_kind = (obj == OBJ_GOLD) || (obj == OBJ_STONE) || (obj == OBJ_DIAMOND);
	assign draw_obj  = obj;

	always_comb begin
		state_d     = state;
		obj_d       = obj;
		draw_start  = 1'b0;
		place_reset = 1'b0;
		place_step  = 1'b0;
		level_up    = 1'b0;
		case (state)
			ST_BOOT: begin
				obj_d   = OBJ_START;
				state_d = ST_CMD;
			end
			ST_CMD: begin
				draw_start = 1'b1;
				state_d    = ST_WAIT;
			end
			// the item counter moves with the done strobe
			ST_WAIT: begin
				if (draw_done) begin
					place_step = item_kind;
					state_d    = ST_NEXT;
				end
			end
			// bookkeeping cycle, picks what follows the finished object
			ST_NEXT: begin
				state_d = ST_CMD;
				case (obj)
					OBJ_START: state_d = ST_GO_WAIT;
					OBJ_BG, OBJ_GOLD, OBJ_STONE, OBJ_DIAMOND: begin
						if (!gold_full)
							obj_d = OBJ_GOLD;
						else if (!stone_full)
							obj_d = OBJ_STONE;
						else if (!diamond_full)
							obj_d = OBJ_DIAMOND;
						else
							obj_d = OBJ_HOOK0;
					end
					OBJ_HOOK0: obj_d = mode ? OBJ_HOOK1 : OBJ_NUM;
					OBJ_HOOK1: obj_d = OBJ_NUM;
					OBJ_NUM:   state_d = ST_GAME;
					OBJ_OVER:  state_d = ST_OVER_PRESS;
					OBJ_NEXT:  state_d = ST_NEXT_PRESS;
					default:   state_d = ST_BOOT;
				endcase
			end
			ST_GO_WAIT: begin
				if (go)
					state_d = ST_CLEAR;
			end
			// placer restarts so every redraw shows the same layout
			ST_CLEAR: begin
				place_reset = 1'b1;
				obj_d       = OBJ_BG;
				state_d     = ST_CMD;
			end
			// ticks outside this state are dropped
			ST_GAME: begin
				if (game_end && !next_level) begin
					obj_d   = OBJ_OVER;
					state_d = ST_CMD;
				end else if (game_end && next_level) begin
					obj_d   = OBJ_NEXT;
					state_d = ST_CMD;
				end else if (frame) begin
					state_d = ST_CLEAR;
				end
			end
			ST_OVER_PRESS: begin
				if (go)
					state_d = ST_OVER_RELEASE;
			end
			ST_OVER_RELEASE: begin
				if (!go) begin
					obj_d   = OBJ_START;
					state_d = ST_CMD;
				end
			end
			ST_NEXT_PRESS: begin
				if (go)
					state_d = ST_LEVEL_UP;
			end
			ST_LEVEL_UP: begin
				level_up = 1'b1;
				state_d  = ST_CLEAR;
			end
			default: state_d = ST_BOOT;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			state <= ST_BOOT;
			obj   <= OBJ_BG;
		end else begin
			state <= state_d;
			obj   <= obj_d;
		end
	end

endmodule

`default_nettype wire

// File: source/view_top.sv
/*
 * Display side of the miner game. Joins the sequencer, painter, item placer
 * and frame divider and exposes the pixel-write port.
 */
`timescale 1ns/1ps
`default_nettype none

module view_top import miner_pkg::*; (
	input  wire        clk,
	input  wire        resetn,
	input  wire        go,
	input  wire        mode,
	input  wire        game_end,
	input  wire        next_level,
	output logic [5:0] pix_x,
	output logic [5:0] pix_y,
	output logic [2:0] pix_color,
	output logic       pix_we
);

	draw_obj_t  draw_obj;
	logic       draw_start, draw_done;
	logic       place_reset, place_step, level_up;
	logic       gold_full, stone_full, diamond_full;
	logic [5:0] item_x, item_y;
	logic [3:0] level;
	logic       frame;

	frame_tick u_frame_tick (
		.clk    (clk),
		.resetn (resetn),
		.frame  (frame)
	);

	item_placer u_item_placer (
		.clk          (clk),
		.resetn       (resetn),
		.place_reset  (place_reset),
		.place_step   (place_step),
		.level_up     (level_up),
		.draw_obj     (draw_obj),
		.item_x       (item_x),
		.item_y       (item_y),
		.gold_full    (gold_full),
		.stone_full   (stone_full),
		.diamond_full (diamond_full),
		.level        (level)
	);

	rect_painter u_rect_painter (
		.clk        (clk),
		.resetn     (resetn),
		.draw_start (draw_start),
		.draw_obj   (draw_obj),
		.item_x     (item_x),
		.item_y     (item_y),
		.level      (level),
		.pix_x      (pix_x),
		.pix_y      (pix_y),
		.pix_color  (pix_color),
		.pix_we     (pix_we),
		.draw_done  (draw_done)
	);

	view_sequencer u_view_sequencer (
		.clk          (clk),
		.resetn       (resetn),
		.go           (go),
		.mode         (mode),
		.game_end     (game_end),
		.next_level   (next_level),
		.frame        (frame),
		.draw_done    (draw_done),
		.gold_full    (gold_full),
		.stone_full   (stone_full),
		.diamond_full (diamond_full),
		.draw_start   (draw_start),
		.draw_obj     (draw_obj),
		.place_reset  (place_reset),
		.place_step   (place_step),
		.level_up     (level_up)
	);

endmodule

`default_nettype wire

// File: testbench/tb_view_top.sv
/*
 * Testbench for view_top. Applies a table of game scenarios, groups pixel
 * writes into draw commands and checks each one against a screen model.
 */
`timescale 1ns/1ps
`default_nettype none

`include "miner_defs.svh"

module tb_view_top;

	localparam int BG_PIX     = `MINER_SCR_W * `MINER_SCR_H;
	localparam int ITEM_PIX   = `MINER_ITEM_W * `MINER_ITEM_H;
	localparam int HOOK_PIX   = `MINER_HOOK_W * `MINER_HOOK_H;
	localparam int BANNER_PIX = `MINER_BANNER_W * `MINER_BANNER_H;
	localparam int X_SPAN     = `MINER_SCR_W - `MINER_ITEM_W + 1;
	localparam int Y_SPAN     = `MINER_SCR_H - `MINER_ITEM_H - 8 + 1;

	typedef struct packed {
		logic [2:0]  color;
		logic [15:0] len;
		logic [5:0]  x;
		logic [5:0]  y;
	} run_t;

	typedef struct {
		string      name;
		bit         mode;
		int         end_off;
		bit         next_lvl;
		logic [2:0] end_color;
	} scen_t;

	logic       clk, resetn, go, mode, game_end, next_level;
	wire  [5:0] pix_x, pix_y;
	wire  [2:0] pix_color;
	wire        pix_we;

	run_t        runs[$];
	run_t        cur;
	logic        in_run;
	logic [5:0]  prev_x, prev_y;
	scen_t       rows[4];
	int          cycle = 0;
	int          limit = 0;
	logic [31:0] rng;
	string       test_name = "reset";

	view_top dut (
		.clk        (clk),
		.resetn     (resetn),
		.go         (go),
		.mode       (mode),
		.game_end   (game_end),
		.next_level (next_level),
		.pix_x      (pix_x),
		.pix_y      (pix_y),
		.pix_color  (pix_color),
		.pix_we     (pix_we)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	task automatic stop_with_failure(input string reason);
		$display("%s", reason);
		$display("Checks failed");
		$fatal(1, "run stopped at first error");
	endtask

	task automatic check_value(input string what, input int expected, input int actual);
		if (expected != actual)
			stop_with_failure($sformatf("ERROR [%s] %s: expected %0d, actual %0d",
				test_name, what, expected, actual));
	endtask

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] v;
		v = s ^ (s << 13);
		v = v ^ (v >> 17);
		v = v ^ (v << 5);
		return v;
	endfunction

	// Galois form, taps x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_step(input logic [15:0] v);
		return (v >> 1) ^ (v[0] ? 16'hb400 : 16'h0000);
	endfunction

	function automatic int screen_pixels(input bit m, input int lvl);
		int items;
		items = `MINER_BASE_GOLD + `MINER_BASE_STONE + `MINER_BASE_DIAMOND + 3 * lvl;
		return BG_PIX + items * ITEM_PIX + (m ? 2 : 1) * HOOK_PIX + lvl + 1;
	endfunction

	// one command is one unbroken run of pixel writes, walked x first
	always @(posedge clk) begin
		if (resetn !== 1'b1) begin
			in_run = 1'b0;
		end else if (pix_we === 1'b1) begin
			if (!in_run) begin
				cur.color = pix_color;
				cur.len   = 16'd1;
				cur.x     = pix_x;
				cur.y     = pix_y;
				in_run    = 1'b1;
			end else begin
				check_value("color inside one command", int'(cur.color), int'(pix_color));
				if (pix_y == prev_y) begin
					check_value("x step inside one row", int'(prev_x) + 1, int'(pix_x));
				end else begin
					check_value("x at start of next row", int'(cur.x), int'(pix_x));
					check_value("y step to next row", int'(prev_y) + 1, int'(pix_y));
				end
				cur.len = cur.len + 16'd1;
			end
			prev_x = pix_x;
			prev_y = pix_y;
		end else if (in_run) begin
			runs.push_back(cur);
			in_run = 1'b0;
		end
	end

	always @(posedge clk) begin
		cycle <= cycle + 1;
		if (limit > 0 && cycle >= limit)
			stop_with_failure($sformatf("timeout: no result after %0d cycles", cycle));
	end

	task automatic check_run(input string what, input run_t r, input logic [2:0] color,
			input int len, input int x, input int y);
		check_value({what, " color"}, int'(color), int'(r.color));
		check_value({what, " length"}, len, int'(r.len));
		check_value({what, " x"}, x, int'(r.x));
		check_value({what, " y"}, y, int'(r.y));
	endtask

	task automatic expect_run(input string what, input logic [2:0] color, input int len,
			input int x, input int y);
		run_t r;
		while (runs.size() == 0)
			@(negedge clk);
		r = runs.pop_front();
		check_run(what, r, color, len, x, y);
	endtask

	// everything after the background, item origins from the LFSR model
	task automatic check_screen_items(input bit m, input int lvl);
		logic [15:0] lfsr;
		int          counts[3];
		logic [2:0]  colors[3];
		lfsr   = `MINER_LFSR_SEED;
		counts = '{`MINER_BASE_GOLD + lvl, `MINER_BASE_STONE + lvl, `MINER_BASE_DIAMOND + lvl};
		colors = '{`MINER_COL_GOLD, `MINER_COL_STONE, `MINER_COL_DIAMOND};
		for (int k = 0; k < 3; k++) begin
			for (int i = 0; i < counts[k]; i++) begin
				expect_run($sformatf("item kind %0d number %0d", k, i), colors[k], ITEM_PIX,
					int'(lfsr[7:0]) % X_SPAN, 8 + int'(lfsr[15:8]) % Y_SPAN);
				lfsr = lfsr_step(lfsr);
			end
		end
		expect_run("hook 0", `MINER_COL_HOOK, HOOK_PIX, 19, 1);
		if (m)
			expect_run("hook 1", `MINER_COL_HOOK, HOOK_PIX, 10, 1);
		expect_run("number bar", `MINER_COL_NUM, lvl + 1, 0, 0);
	endtask

	// frame redraws may come first, each must match the screen exactly
	task automatic await_banner(input bit m, input int lvl, input logic [2:0] color,
			output int redraws);
		run_t r;
		bit   found;
		redraws = 0;
		found   = 1'b0;
		while (!found) begin
			while (runs.size() == 0)
				@(negedge clk);
			r = runs.pop_front();
			if (r.color == `MINER_COL_BG) begin
				check_run("redraw background", r, `MINER_COL_BG, BG_PIX, 0, 0);
				check_screen_items(m, lvl);
				redraws = redraws + 1;
			end else begin
				check_run("end banner", r, color, BANNER_PIX, `MINER_BANNER_X, `MINER_BANNER_Y);
				found = 1'b1;
			end
		end
	endtask

	// random idle time with the painter quiet, then one press and release
	task automatic press_go();
		int wait_cycles;
		rng         = xorshift32(rng);
		wait_cycles = 4 + int'(rng[3:0]);
		repeat (wait_cycles) begin
			@(negedge clk);
			check_value("no pixel write while waiting for go", 0, int'(pix_we));
		end
		go = 1'b1;
		repeat (3) @(negedge clk);
		go = 1'b0;
	endtask

	initial begin
		int redraws;
		int lvl;
		int pix_sum;
		go         = 1'b0;
		mode       = 1'b0;
		game_end   = 1'b0;
		next_level = 1'b0;
		resetn     = 1'b0;
		rng        = 32'hf286587c;

		// name, mode, game_end offset, next_level, end banner color
		rows[0] = '{"frame_redraw_over", 1'b0, 2100, 1'b0, `MINER_COL_OVER};
		rows[1] = '{"two_hooks_over", 1'b1, 30, 1'b0, `MINER_COL_OVER};
		rows[2] = '{"next_level", 1'b0, 60, 1'b1, `MINER_COL_NEXT};
		rows[3] = '{"level_one_two_hooks", 1'b1, 500, 1'b0, `MINER_COL_OVER};

		lvl     = 0;
		pix_sum = BANNER_PIX;
		foreach (rows[i]) begin
			pix_sum = pix_sum + 2 * BANNER_PIX + screen_pixels(rows[i].mode, lvl);
			if (rows[i].next_lvl) begin
				lvl     = lvl + 1;
				pix_sum = pix_sum + BANNER_PIX + screen_pixels(rows[i].mode, lvl);
			end
		end
		limit = 20 * pix_sum;

		repeat (8) @(negedge clk);
		resetn = 1'b1;

		lvl = 0;
		foreach (rows[i]) begin
			test_name = rows[i].name;
			mode      = rows[i].mode;
			expect_run("title banner", `MINER_COL_START, BANNER_PIX,
				`MINER_BANNER_X, `MINER_BANNER_Y);
			press_go();
			expect_run("background", `MINER_COL_BG, BG_PIX, 0, 0);
			check_screen_items(mode, lvl);
			repeat (rows[i].end_off) @(negedge clk);
			game_end   = 1'b1;
			next_level = rows[i].next_lvl;
			await_banner(mode, lvl, rows[i].end_color, redraws);
			game_end   = 1'b0;
			next_level = 1'b0;
			if (rows[i].end_off > `MINER_FRAME_DIV)
				check_value("redraw after frame tick", 1, int'(redraws > 0));
			if (rows[i].next_lvl) begin
				press_go();
				lvl = lvl + 1;
				expect_run("level up background", `MINER_COL_BG, BG_PIX, 0, 0);
				check_screen_items(mode, lvl);
				repeat (20) @(negedge clk);
				game_end = 1'b1;
				await_banner(mode, lvl, `MINER_COL_OVER, redraws);
				game_end = 1'b0;
			end
			press_go();
		end

		test_name = "final_title";
		expect_run("title banner", `MINER_COL_START, BANNER_PIX,
			`MINER_BANNER_X, `MINER_BANNER_Y);
		$display("All checks passed");
		$finish;
	end

endmodule

`default_nettype wire

// File: src.f
+incdir+source
source/miner_pkg.sv
source/frame_tick.sv
source/item_placer.sv
source/rect_painter.sv
source/view_sequencer.sv
source/view_top.sv
testbench/tb_view_top.sv

// File: Makefile
# Verilator build and run for the miner display testbench

VERILATOR ?= verilator
TOP       ?= tb_view_top
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --timescale 1ns/1ps

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
